// ==== project.f ====
+incdir+include
logic/conv_out_pkg.sv
logic/bias_cfg_axil.sv
logic/bias_regs.sv
logic/psum_capture.sv
logic/bias_requant.sv
logic/conv_out_top.sv
bench/conv_out_tb.sv

// ==== Bender.yml ====
package:
  name: conv_out

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/conv_out_pkg.sv
      - logic/bias_cfg_axil.sv
      - logic/bias_regs.sv
      - logic/psum_capture.sv
      - logic/bias_requant.sv
      - logic/conv_out_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/conv_out_tb.sv

// ==== bench/conv_out_tb.sv ====
`include "conv_out_defs.svh"

module conv_out_tb;
    import conv_out_pkg::*;

    localparam int N_RAND  = 160;  // Shift 0, ReLU off
    localparam int N_ZERO  = 24;   // Row index 0
    localparam int N_SHIFT = 24;   // Per shift and ReLU setting
    localparam int N_BP    = 160;  // Random out_ready
    localparam int N_LAT   = 16;
    localparam int TOTAL_BEATS = N_RAND + N_ZERO + 2 * 5 * N_SHIFT + N_BP + N_LAT;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_BEATS + 500;

    logic                             clk, rst_n;
    logic [`CONV_AXIL_ADDR_WIDTH-1:0] s_axil_awaddr, s_axil_araddr;
    logic                             s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic [`CONV_AXIL_DATA_WIDTH-1:0] s_axil_wdata, s_axil_rdata;
    logic [1:0]                       s_axil_bresp, s_axil_rresp;
    logic                             s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic                             s_axil_rvalid, s_axil_rready;
    logic                             in_valid, in_ready, out_valid, out_ready;
    psum_beat_t                       in_beat;
    out_beat_t                        out_beat;

    logic [`CONV_BIAS_SET_WIDTH-1:0]  shadow_bias [`CONV_BIAS_SETS];  // Host view of the sets
    requant_ctrl_t                    shadow_ctrl;
    out_beat_t                        expect_q [$];
    out_beat_t                        exp_beat;
    int                               cycle = 0, beats_out = 0, lat_accept_cycle = 0;
    bit                               ready_random = 0, lat_arm = 0, lat_pending = 0;
    int unsigned                      seed_dummy;
    int                               shift_list [5] = '{2, 5, 9, 14, 19};

    conv_out_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    function automatic out_beat_t calc_expected(input psum_beat_t beat);
        out_beat_t               res;
        logic [15:0]             set;
        logic signed [7:0]       b;
        int                      acc;
        for (int i = 0; i < `CONV_LANES; i++) begin
            b = '0;  // Row 0 adds nothing
            if (beat.row_idx != 0) begin
                set = shadow_bias[(i / 2) * 16 + int'(beat.row_idx) - 1];
                b   = (i % 2) ? set[15:8] : set[7:0];  // Odd lane takes the high byte
            end
            acc = int'(beat.psum[i]) + int'(b);
            acc = acc >>> shadow_ctrl.shift;
            if (shadow_ctrl.relu_en && acc < 0) acc = 0;
            if (acc > 127) acc = 127;
            else if (acc < -128) acc = -128;
            res.lane[i] = acc[7:0];
        end
        return res;
    endfunction

    // Mode 0 small, 1 full range, 2 near the 20-bit limits, 3 mixed
    function automatic psum_t rand_psum(input int mode);
        int v, sel;
        sel = (mode == 3) ? int'($urandom % 3) : mode;
        case (sel)
            0: v = int'($urandom % 601) - 300;
            1: v = int'($urandom % (1 << 20)) - (1 << 19);
            default: begin
                v = int'($urandom % 64);
                v = ($urandom % 2) ? (1 << 19) - 1 - v : v - (1 << 19);
            end
        endcase
        return psum_t'(v);
    endfunction

    ////////////////////////////////
    // AXI4-Lite host
    ////////////////////////////////
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data, input int w_lag);
        bit aw_done, w_done, b_done;
        int lag;
        aw_done = 0;
        w_done  = 0;
        b_done  = 0;
        lag     = w_lag;
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wvalid  = (w_lag == 0);  // W may trail AW
        s_axil_bready  = 1'b1;
        while (!b_done) begin
            @(posedge clk);
            if (s_axil_awvalid && s_axil_awready) aw_done = 1;
            if (s_axil_wvalid && s_axil_wready) w_done = 1;
            if (s_axil_bvalid) begin
                b_done = 1;
                assert (s_axil_bresp == 2'b00) else abort_run($sformatf(
                    "[ERROR] %0t: write 0x%03h got bresp %0d", $time, addr, s_axil_bresp));
            end
            @(negedge clk);
            if (aw_done) s_axil_awvalid = 1'b0;
            if (w_done) s_axil_wvalid = 1'b0;
            else if (lag > 0) begin
                lag--;
                if (lag == 0) s_axil_wvalid = 1'b1;
            end
        end
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        bit ar_done, r_done;
        ar_done = 0;
        r_done  = 0;
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        s_axil_rready  = 1'b1;
        while (!r_done) begin
            @(posedge clk);
            if (s_axil_arvalid && s_axil_arready) ar_done = 1;
            if (s_axil_rvalid && s_axil_rready) begin
                data   = s_axil_rdata;
                r_done = 1;
                assert (s_axil_rresp == 2'b00) else abort_run($sformatf(
                    "[ERROR] %0t: read 0x%03h got rresp %0d", $time, addr, s_axil_rresp));
            end
            @(negedge clk);
            if (ar_done) s_axil_arvalid = 1'b0;
        end
        s_axil_rready = 1'b0;
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        axil_read(addr, got);
        assert (got === exp) else abort_run($sformatf(
            "[ERROR] %0t: read 0x%03h gave 0x%08h, expected 0x%08h", $time, addr, got, exp));
    endtask

    task automatic check_all_bias();
        for (int i = 0; i < `CONV_BIAS_SETS; i++) begin
            check_read(`CONV_BIAS_BASE + 12'(4 * i), {16'h0, shadow_bias[i]});
        end
    endtask

    task automatic set_ctrl(input int shift, input bit relu);
        logic [31:0] word;
        shadow_ctrl.shift   = 5'(shift);
        shadow_ctrl.relu_en = relu;
        word = {23'h0, relu, 3'h0, 5'(shift)};  // relu_en bit 8, shift 4:0
        axil_write(`CONV_CTRL_ADDR, word, 0);
        check_read(`CONV_CTRL_ADDR, word);
    endtask

    ////////////////////////////////
    // Stream driver
    ////////////////////////////////
    task automatic send_beat(input psum_beat_t beat);
        @(negedge clk);
        in_valid = 1'b1;
        in_beat  = beat;
        expect_q.push_back(calc_expected(beat));
        do @(posedge clk); while (!in_ready);
        if (lat_arm) begin  // First acceptance of the latency run
            lat_accept_cycle = cycle;
            lat_arm          = 0;
            lat_pending      = 1;
        end
    endtask

    task automatic wait_drain();
        while (expect_q.size() != 0) @(posedge clk);
    endtask

    // Row mode 0 is 1..16, 1 is zero, 2 is 0..16
    task automatic run_stream(input int n, input int row_mode, input int psum_mode);
        psum_beat_t beat;
        for (int k = 0; k < n; k++) begin
            case (row_mode)
                0: beat.row_idx = 5'($urandom % 16 + 1);
                1: beat.row_idx = '0;
                default: beat.row_idx = 5'($urandom % 17);
            endcase
            for (int i = 0; i < `CONV_LANES; i++) begin
                beat.psum[i] = rand_psum(psum_mode);
            end
            send_beat(beat);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait_drain();
    endtask

    // Sink, random stalls when enabled
    always @(negedge clk) begin
        out_ready = ready_random ? 1'($urandom % 2) : 1'b1;
    end

    ////////////////////////////////
    // Checker and watchdog
    ////////////////////////////////
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            assert (expect_q.size() > 0) else abort_run($sformatf(
                "[ERROR] %0t: output beat with nothing expected", $time));
            exp_beat = expect_q.pop_front();
            assert (out_beat === exp_beat) else abort_run($sformatf(
                "[ERROR] %0t: out_beat 0x%016h, expected 0x%016h", $time, out_beat, exp_beat));
            if (lat_pending) begin
                assert (cycle == lat_accept_cycle + 2) else abort_run($sformatf(
                    "[ERROR] %0t: first output %0d cycles after acceptance, expected 2",
                    $time, cycle - lat_accept_cycle));
                lat_pending = 0;
            end
            beats_out++;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) abort_run("Timeout, the run did not finish in time");
    end

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////
    initial begin
        logic [11:0] unused_addr [4];
        unused_addr = '{12'h004, 12'h0fc, 12'h200, 12'hffc};
        seed_dummy = $urandom(32'h4fd4);
        rst_n = 1'b0;
        {s_axil_awaddr, s_axil_awvalid, s_axil_wdata, s_axil_wvalid, s_axil_bready} = '0;
        {s_axil_araddr, s_axil_arvalid, s_axil_rready} = '0;
        in_valid    = 1'b0;
        in_beat     = '0;
        out_ready   = 1'b1;
        shadow_ctrl = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Bias sets, upper half of each word is junk
        for (int i = 0; i < `CONV_BIAS_SETS; i++) begin
            shadow_bias[i] = 16'($urandom);
            axil_write(`CONV_BIAS_BASE + 12'(4 * i), {16'($urandom), shadow_bias[i]}, i % 3);
        end
        check_all_bias();
        foreach (unused_addr[j]) axil_write(unused_addr[j], $urandom, 1);
        check_all_bias();
        check_read(`CONV_CTRL_ADDR, 32'h0);

        set_ctrl(0, 0);
        run_stream(N_RAND, 0, 0);
        run_stream(N_ZERO, 1, 0);

        for (int r = 1; r >= 0; r--) begin
            foreach (shift_list[s]) begin
                set_ctrl(shift_list[s], r[0]);
                run_stream(N_SHIFT, 2, 3);
            end
        end

        // Back-pressure, order and count
        set_ctrl(3, 1);
        ready_random = 1;
        run_stream(N_BP, 2, 3);
        ready_random = 0;

        repeat (3) @(negedge clk);
        lat_arm = 1;
        run_stream(N_LAT, 0, 1);

        if (expect_q.size() == 0 && beats_out == TOTAL_BEATS) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run($sformatf("Only %0d of %0d beats came out", beats_out, TOTAL_BEATS));
        end
    end

endmodule

// ==== logic/conv_out_top.sv ====
`include "conv_out_defs.svh"

module conv_out_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // AXI4-Lite slave
    input  logic [`CONV_AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
    input  logic                               s_axil_awvalid,
    output logic                               s_axil_awready,
    input  logic [`CONV_AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
    input  logic                               s_axil_wvalid,
    output logic                               s_axil_wready,
    output logic [1:0]                         s_axil_bresp,
    output logic                               s_axil_bvalid,
    input  logic                               s_axil_bready,
    input  logic [`CONV_AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
    input  logic                               s_axil_arvalid,
    output logic                               s_axil_arready,
    output logic [`CONV_AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
    output logic [1:0]                         s_axil_rresp,
    output logic                               s_axil_rvalid,
    input  logic                               s_axil_rready,
    // Partial sums in
    input  logic                               in_valid,
    output logic                               in_ready,
    input  conv_out_pkg::psum_beat_t           in_beat,
    // Requantized out
    output logic                               out_valid,
    input  logic                               out_ready,
    output conv_out_pkg::out_beat_t            out_beat
);
    import conv_out_pkg::*;

    logic                               bias_we, load, cap_valid, cap_ready;
    logic [`CONV_BIAS_ADDR_WIDTH-1:0]   bias_addr, rd_addr;
    logic [`CONV_BIAS_SET_WIDTH-1:0]    bias_data, rd_data;
    logic [`CONV_ROW_IDX_WIDTH-1:0]     row_idx;
    requant_ctrl_t                      ctrl;
    bias_vec_t                          bias;
    psum_vec_t                          cap_psum;

    bias_cfg_axil u_cfg (.*);  // Host config and readback

    bias_regs u_bias (.*);     // Bias lookup, beside capture

    psum_capture u_cap (.*);   // Psum stage register

    bias_requant u_rq (.*);    // Add, shift, ReLU, saturate

endmodule

// ==== logic/bias_requant.sv ====
`include "conv_out_defs.svh"

module bias_requant (
    input  logic                               clk,
    input  logic                               rst_n,
    // From capture stage and bias lookup
    input  logic                               cap_valid,
    output logic                               cap_ready,
    input  conv_out_pkg::psum_vec_t            cap_psum,
    input  conv_out_pkg::bias_vec_t            bias,
    input  conv_out_pkg::requant_ctrl_t        ctrl,
    // int8 stream out
    output logic                               out_valid,
    input  logic                               out_ready,
    output conv_out_pkg::out_beat_t            out_beat
);
    import conv_out_pkg::*;

    localparam int SUM_W   = `CONV_PSUM_WIDTH + 1;  // One guard bit for the add
    localparam int SAT_MAX = 2**(`CONV_OUT_WIDTH-1) - 1;
    localparam int SAT_MIN = -(2**(`CONV_OUT_WIDTH-1));

    logic      take;
    out_beat_t beat_nxt;

    ////////////////////////////////
    // Per-lane requantization
    ////////////////////////////////
    always_comb begin
        logic signed [SUM_W-1:0] sum;
        logic signed [SUM_W-1:0] shifted;
        beat_nxt = '0;
        for (int i = 0; i < `CONV_LANES; i++) begin
            sum     = $signed(cap_psum[i]) + $signed(bias.lane[i]);  // Both sign-extend
            shifted = sum >>> ctrl.shift;
            if (ctrl.relu_en && shifted < 0) begin
                shifted = '0;
            end
            // Clamp to int8
            if (shifted > SAT_MAX) begin
                beat_nxt.lane[i] = out_t'(SAT_MAX);
            end else if (shifted < SAT_MIN) begin
                beat_nxt.lane[i] = out_t'(SAT_MIN);
            end else begin
                beat_nxt.lane[i] = shifted[`CONV_OUT_WIDTH-1:0];
            end
        end
    end

    ////////////////////////////////
    // Output register
    ////////////////////////////////
    assign cap_ready = !out_valid || out_ready;
    assign take      = cap_valid && cap_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) out_beat <= beat_nxt;
    end

    // Held output under back-pressure
    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== logic/psum_capture.sv ====
`include "conv_out_defs.svh"

module psum_capture (
    input  logic                               clk,
    input  logic                               rst_n,
    // Partial-sum stream in
    input  logic                               in_valid,
    output logic                               in_ready,
    input  conv_out_pkg::psum_beat_t           in_beat,
    // Lookup request to bias_regs
    output logic                               load,
    output logic [`CONV_ROW_IDX_WIDTH-1:0]     row_idx,
    // Aligned stage out
    output logic                               cap_valid,
    output conv_out_pkg::psum_vec_t            cap_psum,
    input  logic                               cap_ready
);
    import conv_out_pkg::*;

    logic      stage_full;
    psum_vec_t psum_q;

    ////////////////////////////////
    // Handshake
    ////////////////////////////////
    assign in_ready = !stage_full || cap_ready;  // Empty or draining this cycle
    assign load     = in_valid && in_ready;      // One pulse per accepted beat
    assign row_idx  = in_beat.row_idx;           // Lookup runs beside the capture

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_full <= 1'b0;
        end else if (load) begin
            stage_full <= 1'b1;
        end else if (cap_ready) begin
            stage_full <= 1'b0;  // Consumer took it, nothing new
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (load) psum_q <= in_beat.psum;
    end

    assign cap_valid = stage_full;  // Biases valid on the same cycle
    assign cap_psum  = psum_q;

    // Stalled producer keeps its beat
    a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_beat));

endmodule

// ==== logic/bias_regs.sv ====
`include "conv_out_defs.svh"

module bias_regs (
    input  logic                               clk,
    input  logic                               rst_n,
    // Host side, one set per write
    input  logic                               bias_we,
    input  logic [`CONV_BIAS_ADDR_WIDTH-1:0]   bias_addr,
    input  logic [`CONV_BIAS_SET_WIDTH-1:0]    bias_data,
    input  logic [`CONV_BIAS_ADDR_WIDTH-1:0]   rd_addr,
    output logic [`CONV_BIAS_SET_WIDTH-1:0]    rd_data,
    // Stream side lookup
    input  logic                               load,
    input  logic [`CONV_ROW_IDX_WIDTH-1:0]     row_idx,
    output conv_out_pkg::bias_vec_t            bias
);
    import conv_out_pkg::*;

    localparam int ROW_SEL_W = $clog2(`CONV_ROW_NUM);

    // Index {array, row}
    logic [`CONV_BIAS_SET_WIDTH-1:0] bias_mem [`CONV_BIAS_SETS];
    logic [ROW_SEL_W-1:0]            row_sel;
    bias_vec_t                       bias_nxt;

    ////////////////////////////////
    // Set storage
    ////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CONV_BIAS_SETS; i++) begin
                bias_mem[i] <= '0;
            end
        end else if (bias_we) begin
            bias_mem[bias_addr] <= bias_data;
        end
    end

    assign rd_data = bias_mem[rd_addr];  // Readback, no latency

    ////////////////////////////////
    // Row lookup
    ////////////////////////////////
    // Row index k picks row k-1, 16 wraps to 15
    assign row_sel = ROW_SEL_W'(row_idx - 1'b1);

    always_comb begin
        bias_nxt = '0;  // Row 0 means no bias
        if (row_idx != '0) begin
            for (int a = 0; a < `CONV_SA_ROW_NUM; a++) begin
                bias_nxt.lane[2*a] =
                    bias_mem[a*`CONV_ROW_NUM + int'(row_sel)][`CONV_BIAS_WIDTH-1:0];
                bias_nxt.lane[2*a+1] =
                    bias_mem[a*`CONV_ROW_NUM + int'(row_sel)][`CONV_BIAS_SET_WIDTH-1:`CONV_BIAS_WIDTH];
            end
        end
    end

    // Same edge as the psum stage register
    always_ff @(posedge clk) begin
        if (load) bias <= bias_nxt;
    end

    // Upstream must never send a row past the last array row
    a_row_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> row_idx <= `CONV_ROW_NUM);

endmodule

// ==== logic/bias_cfg_axil.sv ====
`include "conv_out_defs.svh"

module bias_cfg_axil (
    input  logic                               clk,
    input  logic                               rst_n,
    // Write address and data
    input  logic [`CONV_AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
    input  logic                               s_axil_awvalid,
    output logic                               s_axil_awready,
    input  logic [`CONV_AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
    input  logic                               s_axil_wvalid,
    output logic                               s_axil_wready,
    output logic [1:0]                         s_axil_bresp,
    output logic                               s_axil_bvalid,
    input  logic                               s_axil_bready,
    // Read
    input  logic [`CONV_AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
    input  logic                               s_axil_arvalid,
    output logic                               s_axil_arready,
    output logic [`CONV_AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
    output logic [1:0]                         s_axil_rresp,
    output logic                               s_axil_rvalid,
    input  logic                               s_axil_rready,
    // Bias register file
    output logic                               bias_we,
    output logic [`CONV_BIAS_ADDR_WIDTH-1:0]   bias_addr,
    output logic [`CONV_BIAS_SET_WIDTH-1:0]    bias_data,
    output logic [`CONV_BIAS_ADDR_WIDTH-1:0]   rd_addr,
    input  logic [`CONV_BIAS_SET_WIDTH-1:0]    rd_data,
    output conv_out_pkg::requant_ctrl_t        ctrl
);
    import conv_out_pkg::*;

    localparam logic [`CONV_AXIL_ADDR_WIDTH-1:0] CTRL_ADDR = `CONV_CTRL_ADDR;
    localparam logic [`CONV_AXIL_ADDR_WIDTH-1:0] BIAS_BASE = `CONV_BIAS_BASE;
    localparam logic [`CONV_AXIL_ADDR_WIDTH-1:0] BIAS_END  = `CONV_BIAS_BASE + 4 * `CONV_BIAS_SETS;

    logic                               aw_full, w_full;   // Held halves of a write
    logic [`CONV_AXIL_ADDR_WIDTH-1:0]   aw_addr_q;
    logic [`CONV_AXIL_DATA_WIDTH-1:0]   w_data_q;
    logic                               aw_hs, w_hs, wr_fire, ar_hs;
    logic [`CONV_AXIL_ADDR_WIDTH-1:0]   wr_addr, wr_offs, rd_offs;
    cfg_word_u                          wr_cfg, rd_cfg;
    logic                               wr_is_ctrl, wr_is_bias, rd_is_ctrl, rd_is_bias;

    ////////////////////////////////
    // Write channel
    ////////////////////////////////
    assign s_axil_awready = !aw_full && !s_axil_bvalid;  // Stall while response pending
    assign s_axil_wready  = !w_full  && !s_axil_bvalid;
    assign aw_hs = s_axil_awvalid && s_axil_awready;
    assign w_hs  = s_axil_wvalid  && s_axil_wready;

    // Fire as soon as both halves are here, held or arriving
    assign wr_fire = (aw_full || aw_hs) && (w_full || w_hs);
    assign wr_addr = aw_full ? aw_addr_q : s_axil_awaddr;
    assign wr_cfg  = w_full  ? w_data_q  : s_axil_wdata;

    assign wr_offs    = wr_addr - BIAS_BASE;
    assign wr_is_ctrl = (wr_addr[`CONV_AXIL_ADDR_WIDTH-1:2] == CTRL_ADDR[`CONV_AXIL_ADDR_WIDTH-1:2]);
    assign wr_is_bias = (wr_addr >= BIAS_BASE) && (wr_addr < BIAS_END);

    assign bias_we   = wr_fire && wr_is_bias;
    assign bias_addr = wr_offs[`CONV_BIAS_ADDR_WIDTH+1:2];         // Word index
    assign bias_data = {wr_cfg.bias_set.hi, wr_cfg.bias_set.lo};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_full       <= 1'b0;
            w_full        <= 1'b0;
            s_axil_bvalid <= 1'b0;
        end else begin
            if (wr_fire) aw_full <= 1'b0;
            else if (aw_hs) aw_full <= 1'b1;
            if (wr_fire) w_full <= 1'b0;
            else if (w_hs) w_full <= 1'b1;
            if (wr_fire) s_axil_bvalid <= 1'b1;
            else if (s_axil_bready) s_axil_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_addr_q <= s_axil_awaddr;
        if (w_hs)  w_data_q  <= s_axil_wdata;
    end

    // Control register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (wr_fire && wr_is_ctrl) begin
            ctrl.shift   <= wr_cfg.ctrl.shift;
            ctrl.relu_en <= wr_cfg.ctrl.relu_en;
        end
    end

    assign s_axil_bresp = 2'b00;  // Always OKAY

    ////////////////////////////////
    // Read channel
    ////////////////////////////////
    assign s_axil_arready = !s_axil_rvalid;
    assign ar_hs      = s_axil_arvalid && s_axil_arready;
    assign rd_offs    = s_axil_araddr - BIAS_BASE;
    assign rd_addr    = rd_offs[`CONV_BIAS_ADDR_WIDTH+1:2];  // Comb port into bias_regs
    assign rd_is_ctrl = (s_axil_araddr[`CONV_AXIL_ADDR_WIDTH-1:2] == CTRL_ADDR[`CONV_AXIL_ADDR_WIDTH-1:2]);
    assign rd_is_bias = (s_axil_araddr >= BIAS_BASE) && (s_axil_araddr < BIAS_END);

    always_comb begin
        rd_cfg = '0;  // Unmapped reads return zero
        if (rd_is_ctrl) begin
            rd_cfg.ctrl.shift   = ctrl.shift;
            rd_cfg.ctrl.relu_en = ctrl.relu_en;
        end else if (rd_is_bias) begin
            rd_cfg.bias_set.lo = rd_data[`CONV_BIAS_WIDTH-1:0];
            rd_cfg.bias_set.hi = rd_data[`CONV_BIAS_SET_WIDTH-1:`CONV_BIAS_WIDTH];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s_axil_rvalid <= 1'b0;
        else if (ar_hs) s_axil_rvalid <= 1'b1;
        else if (s_axil_rready) s_axil_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (ar_hs) s_axil_rdata <= rd_cfg;
    end

    assign s_axil_rresp = 2'b00;

    // Responses held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid);
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

// ==== logic/conv_out_pkg.sv ====
`include "conv_out_defs.svh"

package conv_out_pkg;

    // Scalar element types
    typedef logic signed [`CONV_PSUM_WIDTH-1:0] psum_t;
    typedef logic signed [`CONV_BIAS_WIDTH-1:0] bias_t;
    typedef logic signed [`CONV_OUT_WIDTH-1:0]  out_t;

    typedef psum_t [`CONV_LANES-1:0] psum_vec_t;  // Eight partial sums

    ////////////////////////////////
    // Stream beats
    ////////////////////////////////
    typedef struct packed {
        logic [`CONV_ROW_IDX_WIDTH-1:0] row_idx;  // 1..16, 0 means no bias
        psum_vec_t                      psum;
    } psum_beat_t;

    // Lane 2a low byte of array a, lane 2a+1 high byte
    typedef struct packed {
        bias_t [`CONV_LANES-1:0] lane;
    } bias_vec_t;

    typedef struct packed {
        out_t [`CONV_LANES-1:0] lane;
    } out_beat_t;

    typedef struct packed {
        logic [`CONV_SHIFT_WIDTH-1:0] shift;  // Arithmetic right shift
        logic                         relu_en;
    } requant_ctrl_t;

    ////////////////////////////////
    // AXI word views
    ////////////////////////////////
    typedef struct packed {
        logic [`CONV_AXIL_DATA_WIDTH-`CONV_BIAS_SET_WIDTH-1:0] rsvd;
        bias_t                                                 hi;
        bias_t                                                 lo;
    } cfg_bias_set_t;

    typedef struct packed {
        logic [`CONV_AXIL_DATA_WIDTH-10:0] rsvd_hi;
        logic                              relu_en;  // Bit 8
        logic [2:0]                        rsvd_lo;
        logic [`CONV_SHIFT_WIDTH-1:0]      shift;    // Bits 4:0
    } cfg_ctrl_t;

    // Decoded by address
    typedef union packed {
        cfg_bias_set_t bias_set;
        cfg_ctrl_t     ctrl;
    } cfg_word_u;

endpackage

// ==== include/conv_out_defs.svh ====
`ifndef CONV_OUT_DEFS_SVH
`define CONV_OUT_DEFS_SVH

////////////////////////////////
// Array geometry
////////////////////////////////
`define CONV_SA_ROW_NUM      4    // Arrays stacked in the core
`define CONV_ROW_NUM         16   // Rows per array
`define CONV_PE_PAR_WEIGHT   2    // Biases per set
`define CONV_LANES           (`CONV_SA_ROW_NUM * `CONV_PE_PAR_WEIGHT)
`define CONV_BIAS_SETS       (`CONV_SA_ROW_NUM * `CONV_ROW_NUM)

////////////////////////////////
// Datapath widths
////////////////////////////////
`define CONV_BIAS_WIDTH      8
`define CONV_BIAS_SET_WIDTH  (`CONV_BIAS_WIDTH * `CONV_PE_PAR_WEIGHT)
`define CONV_PSUM_WIDTH      20
`define CONV_OUT_WIDTH       8
`define CONV_ROW_IDX_WIDTH   5    // Row index 0..16
`define CONV_BIAS_ADDR_WIDTH 6    // {array, row}
`define CONV_SHIFT_WIDTH     5

////////////////////////////////
// AXI4-Lite register map
////////////////////////////////
`define CONV_AXIL_ADDR_WIDTH 12
`define CONV_AXIL_DATA_WIDTH 32
`define CONV_CTRL_ADDR       12'h000
`define CONV_BIAS_BASE       12'h100  // Set (a, r) at base + 4*(a*16 + r)

`endif
